// File: dv/team_tb.sv
/*
 * Testbench for the keypad tile with a keypad model and Wishbone memory
 * Inputs change 1 ns after the rising edge; bus and LCD are sampled when stable
 * Key codes and memory wait states come from a Galois LFSR, seed 98
 */
`timescale 1ns/1ps
`include "team_settings.svh"

module team_tb;
   localparam int N_SEQ       = 20;
   localparam int SCAN_PERIOD = 4 * `TEAM_SCAN_DIV;
   localparam int LCD_XFER    = `TEAM_LCD_SETUP + `TEAM_LCD_PULSE + `TEAM_LCD_HOLD + 2;
   localparam int KEY_CYCLES  = (SCAN_PERIOD + 2 * (4 + 3) + 3 * LCD_XFER) * 4;
   localparam int N_KEYS      = 1 + N_SEQ + 2 + 2;
   localparam int HOLD_CYCLES = 10 * SCAN_PERIOD;
   localparam int OFF_CYCLES  = 8 * SCAN_PERIOD;
   // Budget per key plus release, the long hold and the disabled window
   localparam int LIMIT = N_KEYS * (KEY_CYCLES + SCAN_PERIOD) + HOLD_CYCLES + OFF_CYCLES;

   logic        clk = 1'b0;
   logic        rst_n = 1'b0;
   logic        en = 1'b1;
   logic        key_down = 1'b0;
   logic [3:0]  key_sel = 4'd0;
   logic [1:0]  mem_wait = 2'd0;
   logic [15:0] lfsr_q = 16'd98;
   logic [3:0]  rows;
   logic [33:0] gpio_in;
   logic [33:0] gpio_out;
   logic [33:0] gpio_oeb;
   logic [31:0] wb_dat_r;
   logic [31:0] wb_dat_w;
   logic [31:0] wb_adr;
   logic [3:0]  wb_sel;
   logic        wb_ack;
   logic        wb_we;
   logic        wb_stb;
   logic        wb_cyc;

   // Expected and seen LCD writes as {rs, byte}
   logic [8:0]  exp_q[$];
   logic [8:0]  got_q[$];
   logic [31:0] rd_adr_q[$];
   logic [3:0]  shown_keys[$];
   logic [3:0]  seq_keys [0:N_SEQ-1];
   int          n_errors = 0;
   int          n_checks = 0;
   int          n_tests = 0;
   int          n_failed = 0;
   int          bus_cycles = 0;
   int          write_cnt = 0;
   int          cyc_off = 0;
   int          shown = 0;

   always #5 clk = ~clk;

   team_top uut (
      .clk(clk), .rst_n_i(rst_n), .en_i(en),
      .gpio_in_i(gpio_in), .gpio_out_o(gpio_out), .gpio_oeb_o(gpio_oeb),
      .wb_dat_i(wb_dat_r), .wb_ack_i(wb_ack), .wb_adr_o(wb_adr), .wb_dat_o(wb_dat_w),
      .wb_sel_o(wb_sel), .wb_we_o(wb_we), .wb_stb_o(wb_stb), .wb_cyc_o(wb_cyc)
   );

   wb_memory_model mem (
      .clk(clk), .rst_n_i(rst_n), .wait_i(mem_wait),
      .adr_i(wb_adr), .dat_i(wb_dat_w), .sel_i(wb_sel), .we_i(wb_we),
      .stb_i(wb_stb), .cyc_i(wb_cyc), .dat_o(wb_dat_r), .ack_o(wb_ack)
   );

   // Keypad: row goes high when the key's column is driven
   always_comb begin
      rows = 4'b0000;
      if (key_down && gpio_out[16 + key_sel[1:0]]) rows[key_sel[3:2]] = 1'b1;
   end
   assign gpio_in = {18'd0, rows, 12'd0};

   // Expected character for a key
   function automatic logic [7:0] key_char(input logic [3:0] k);
      return 8'h41 + 8'(k);
   endfunction

   // Galois step, polynomial x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic [3:0] take_bits(input int n);
      logic [3:0] v;
      v = 4'd0;
      for (int i = 0; i < n; i++) begin
         v      = {v[2:0], lfsr_q[0]};
         lfsr_q = lfsr_next(lfsr_q);
      end
      return v;
   endfunction

   // Inputs on pins 15:12 and 33:20, everything else driven
   function automatic logic [33:0] oeb_map();
      logic [33:0] m;
      for (int i = 0; i < 34; i++) m[i] = (i >= 20) || (i >= 12 && i <= 15);
      return m;
   endfunction

   task automatic check(input string name, input logic [63:0] got,
                        input logic [63:0] expected);
      n_checks++;
      if (got !== expected) begin
         n_errors++;
         $display("Error %s got 0x%0h expected 0x%0h", name, got, expected);
      end
   endtask

   // Line model: clear goes out before the char that would overflow
   task automatic expect_char(input logic [3:0] k);
      if (shown == `TEAM_LCD_COLS) begin
         exp_q.push_back({1'b0, 8'h01});
         shown = 0;
      end
      exp_q.push_back({1'b1, key_char(k)});
      shown++;
      shown_keys.push_back(k);
   endtask

   // All expected LCD writes seen and every char logged
   task automatic wait_idle();
      while (exp_q.size() != 0 || write_cnt != shown_keys.size()) @(posedge clk);
   endtask

   task automatic press(input logic [3:0] k);
      @(posedge clk);
      #1;
      key_sel  = k;
      key_down = 1'b1;
   endtask

   task automatic release_key();
      @(posedge clk);
      #1;
      key_down = 1'b0;
      repeat (SCAN_PERIOD) @(posedge clk);
   endtask

   task automatic show_key(input logic [3:0] k);
      press(k);
      expect_char(k);
      wait_idle();
      release_key();
   endtask

   task automatic end_test(input string name, input int errs_before);
      n_tests++;
      if (n_errors == errs_before) begin
         $display("Test %0d %s: pass", n_tests, name);
      end else begin
         n_failed++;
         $display("Test %0d %s: fail, %0d errors", n_tests, name, n_errors - errs_before);
      end
   endtask

   // LCD latches on the falling edge of E
   always @(negedge gpio_out[1]) begin
      if (rst_n) got_q.push_back({gpio_out[2], gpio_out[11:4]});
   end

   // Compare seen writes against the expected queue
   always @(negedge clk) begin
      logic [8:0] got;
      logic [8:0] want;
      while (got_q.size() != 0) begin
         got = got_q.pop_front();
         if (exp_q.size() == 0) begin
            n_errors++;
            $display("Unexpected LCD write with rs %0d and byte 0x%0h", got[8], got[7:0]);
         end else begin
            want = exp_q.pop_front();
            check("lcd_rs", got[8], want[8]);
            check("lcd_data", got[7:0], want[7:0]);
         end
      end
   end

   // Bus monitor, mid-cycle so everything has settled
   always @(negedge clk) begin
      if (rst_n && wb_cyc && wb_stb && wb_ack) begin
         bus_cycles++;
         if (wb_we) begin
            write_cnt++;
            check("wb_sel_o", wb_sel, 4'hF);
         end else begin
            rd_adr_q.push_back(wb_adr);
         end
      end
      if (rst_n && !en && wb_cyc) cyc_off++;
   end

   // New wait count after every ack
   always @(negedge clk) begin
      if (rst_n && wb_ack) begin
         @(posedge clk);
         #1;
         mem_wait = 2'(take_bits(2));
      end
   end

   initial begin
      repeat (LIMIT) @(posedge clk);
      $display("Timeout after %0d cycles, the DUT stopped making progress", LIMIT);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      int          errs;
      int          cycles_before;
      logic [3:0]  single_key;
      logic [3:0]  off_key;
      logic [3:0]  new_key;
      logic [3:0]  hold_key;
      logic [31:0] log_adr;

      // All keys drawn before the clock runs
      single_key = take_bits(4);
      for (int i = 0; i < N_SEQ; i++) seq_keys[i] = take_bits(4);
      off_key  = take_bits(4);
      new_key  = take_bits(4);
      hold_key = take_bits(4);
      mem_wait = 2'(take_bits(2));

      // Init commands, then pin directions
      errs = n_errors;
      exp_q.push_back({1'b0, 8'h38});
      exp_q.push_back({1'b0, 8'h0C});
      exp_q.push_back({1'b0, 8'h01});
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
      for (int k = 0; k < 16; k++) begin
         mem.words[((`TEAM_CHARMAP_BASE >> 2) + k) % 1024] = {24'd0, key_char(4'(k))};
      end
      check("gpio_oeb_o", gpio_oeb, oeb_map());
      // Upper pins, row pins, LCD RW and pin 0 stay low
      check("gpio_out_o", {gpio_out[33:20], gpio_out[15:12], gpio_out[3], gpio_out[0]},
            20'd0);
      wait_idle();
      end_test("lcd init", errs);

      errs = n_errors;
      rd_adr_q.delete();
      show_key(single_key);
      check("map reads", rd_adr_q.size(), 1);
      if (rd_adr_q.size() != 0) begin
         check("wb_adr_o", rd_adr_q[0], `TEAM_CHARMAP_BASE + 32'(single_key) * 4);
      end
      end_test("single key", errs);

      errs = n_errors;
      for (int i = 0; i < N_SEQ; i++) show_key(seq_keys[i]);
      end_test("key sequence with wrap", errs);

      errs = n_errors;
      check("log writes", write_cnt, shown_keys.size());
      for (int n = 0; n < shown_keys.size(); n++) begin
         log_adr = `TEAM_LOG_BASE + 32'(n % 64) * 4;
         check($sformatf("log[%0d]", n), mem.words[log_adr[11:2]],
               {24'd0, key_char(shown_keys[n])});
      end
      end_test("log contents", errs);

      // A key pressed while disabled is ignored for good
      errs = n_errors;
      cycles_before = bus_cycles;
      @(posedge clk);
      #1;
      en = 1'b0;
      press(off_key);
      repeat (OFF_CYCLES) @(posedge clk);
      release_key();
      check("bus cycles while disabled", bus_cycles, cycles_before);
      check("wb_cyc_o while disabled", cyc_off, 0);
      @(posedge clk);
      #1;
      en = 1'b1;
      // A stale key would show up here as an unexpected write
      repeat (SCAN_PERIOD) @(posedge clk);
      show_key(new_key);
      end_test("chip enable", errs);

      // Long hold gives one char only
      errs = n_errors;
      press(hold_key);
      expect_char(hold_key);
      repeat (HOLD_CYCLES) @(posedge clk);
      wait_idle();
      release_key();
      show_key(hold_key);
      end_test("held key", errs);

      // Let late writes reach the compare process
      repeat (SCAN_PERIOD) @(posedge clk);
      $display("Tests %0d, failed %0d, checks %0d, errors %0d",
               n_tests, n_failed, n_checks, n_errors);
      if (n_errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: dv/wb_memory_model.sv
/*
 * Wishbone classic slave memory for simulation, 1024 words
 * Address bits above 11 are ignored, so the space repeats every 4 KB
 * Wait states per transfer come from wait_i, 0 to 3 cycles
 */
`timescale 1ns/1ps

module wb_memory_model (
   input  logic        clk,
   input  logic        rst_n_i,
   input  logic [1:0]  wait_i,
   input  logic [31:0] adr_i,
   input  logic [31:0] dat_i,
   input  logic [3:0]  sel_i,
   input  logic        we_i,
   input  logic        stb_i,
   input  logic        cyc_i,
   output logic [31:0] dat_o,
   output logic        ack_o
);
   // Read and written by the testbench too
   logic [31:0] words [0:1023];
   logic [1:0]  wait_cnt;
   logic [9:0]  idx;

   assign idx = adr_i[11:2];

   initial begin
      // Each word holds its own byte address as a marker
      for (int i = 0; i < 1024; i++) begin
         words[i] = 32'hBAD0_0000 | (i << 2);
      end
      dat_o    = '0;
      ack_o    = 1'b0;
      wait_cnt = '0;
   end

   always @(posedge clk) begin
      if (!rst_n_i) begin
         ack_o    <= 1'b0;
         wait_cnt <= '0;
      end else begin
         // Ack is a single cycle
         ack_o <= 1'b0;
         if (cyc_i && stb_i && !ack_o) begin
            if (wait_cnt == wait_i) begin
               ack_o    <= 1'b1;
               wait_cnt <= '0;
               if (we_i) begin
                  // Byte lanes
                  for (int b = 0; b < 4; b++) begin
                     if (sel_i[b]) words[idx][8*b +: 8] <= dat_i[8*b +: 8];
                  end
               end else begin
                  dat_o <= words[idx];
               end
            end else begin
               wait_cnt <= wait_cnt + 2'd1;
            end
         end
      end
   end

endmodule

// File: project.f
+incdir+rtl
rtl/team_pkg.sv
rtl/wishbone_manager.sv
rtl/keypad_scanner.sv
rtl/lcd_driver.sv
rtl/team_cpu.sv
rtl/team_top.sv
dv/wb_memory_model.sv
dv/team_tb.sv

// File: rtl/keypad_scanner.sv
/*
 * 4x4 keypad scan, one high column at a time, rows read active high
 * A pressed key is offered once; the column stays put until it is released
 * No debounce beyond the hold-until-release rule
 */
`timescale 1ns/1ps
`include "team_settings.svh"

module keypad_scanner (
   input  logic                clk,
   input  logic                rst_n_i,
   input  logic [3:0]          rows_i,
   output logic [3:0]          cols_o,
   output logic                key_valid_o,
   output team_pkg::key_code_t key_code_o,
   input  logic                key_ready_i
);
   import team_pkg::*;

   localparam int SCAN_DIV = `TEAM_SCAN_DIV;
   localparam int CNT_W    = $clog2(SCAN_DIV + 1);

   scan_state_e      state;
   logic [CNT_W-1:0] div_cnt;
   logic [3:0]       cols_q;
   logic [1:0]       row_idx;
   logic [1:0]       col_idx;
   logic             period_end;
   logic             hit;

   // Rows sampled on the last cycle of a column, when they have settled
   assign period_end = (div_cnt == CNT_W'(SCAN_DIV - 1));
   assign hit        = (state == SCAN_SEEK) && period_end && (rows_i != 4'b0000);

   // Lowest high row wins; column from the one-hot drive
   always_comb begin
      row_idx = 2'd0;
      col_idx = 2'd0;
      for (int i = 3; i >= 0; i--) begin
         if (rows_i[i]) row_idx = 2'(i);
         if (cols_q[i]) col_idx = 2'(i);
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state   <= SCAN_SEEK;
         div_cnt <= '0;
         cols_q  <= 4'b0001;
      end else begin
         case (state)
            SCAN_SEEK: begin
               if (!period_end) begin
                  div_cnt <= div_cnt + 1'b1;
               end else begin
                  div_cnt <= '0;
                  if (hit) begin
                     state <= SCAN_OFFER;
                  end else begin
                     // Next column
                     cols_q <= {cols_q[2:0], cols_q[3]};
                  end
               end
            end
            SCAN_OFFER: begin
               // Column frozen until the key is taken
               if (key_ready_i) state <= SCAN_RELEASE;
            end
            SCAN_RELEASE: begin
               // Same column still driven, so zero rows means this key let go
               if (rows_i == 4'b0000) state <= SCAN_SEEK;
            end
            default: state <= SCAN_SEEK;
         endcase
      end
   end

   // Key number latched at detection
   always_ff @(posedge clk) begin
      if (hit) key_code_o <= {row_idx, col_idx};
   end

   assign cols_o      = cols_q;
   assign key_valid_o = (state == SCAN_OFFER);

   a_cols_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
      $onehot(cols_o));

   // Offer stays put until the consumer takes it
   a_key_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
      (key_valid_o && !key_ready_i) |=> key_valid_o && $stable(key_code_o));

endmodule

// File: rtl/lcd_driver.sv
/*
 * Write-only HD44780 byte sender, RW is held low outside this block
 * No busy-flag polling, fixed setup, pulse and hold counts instead
 * Slow commands such as clear rely on the caller's own pacing
 */
`timescale 1ns/1ps
`include "team_settings.svh"

module lcd_driver (
   input  logic       clk,
   input  logic       rst_n_i,
   input  logic       lcd_valid_i,
   input  logic [7:0] lcd_byte_i,
   input  logic       lcd_rs_i,
   output logic       lcd_ready_o,
   output logic       lcd_en_o,
   output logic       lcd_rs_o,
   output logic [7:0] lcd_data_o
);
   import team_pkg::*;

   localparam int T_SETUP = `TEAM_LCD_SETUP;
   localparam int T_PULSE = `TEAM_LCD_PULSE;
   localparam int T_HOLD  = `TEAM_LCD_HOLD;
   // Counter sized for the longest phase
   localparam int T_MAX   = (T_SETUP > T_PULSE) ?
                            ((T_SETUP > T_HOLD) ? T_SETUP : T_HOLD) :
                            ((T_PULSE > T_HOLD) ? T_PULSE : T_HOLD);
   localparam int CNT_W   = $clog2(T_MAX + 1);

   lcd_state_e       state;
   logic [CNT_W-1:0] cnt;
   logic             phase_end;
   logic             accept;

   assign accept = lcd_valid_i && lcd_ready_o;

   // Last cycle of the current phase
   always_comb begin
      case (state)
         LCD_SETUP: phase_end = (cnt == CNT_W'(T_SETUP - 1));
         LCD_PULSE: phase_end = (cnt == CNT_W'(T_PULSE - 1));
         LCD_HOLD:  phase_end = (cnt == CNT_W'(T_HOLD - 1));
         default:   phase_end = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state <= LCD_IDLE;
         cnt   <= '0;
      end else if (state == LCD_IDLE) begin
         cnt <= '0;
         if (accept) state <= LCD_SETUP;
      end else if (phase_end) begin
         cnt <= '0;
         case (state)
            LCD_SETUP: state <= LCD_PULSE;
            LCD_PULSE: state <= LCD_HOLD;
            default:   state <= LCD_IDLE;
         endcase
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

   // Byte and RS go to the pins on the accepting edge
   always_ff @(posedge clk) begin
      if (accept) begin
         lcd_data_o <= lcd_byte_i;
         lcd_rs_o   <= lcd_rs_i;
      end
   end

   assign lcd_ready_o = (state == LCD_IDLE);
   assign lcd_en_o    = (state == LCD_PULSE);

   // Display latches on the falling edge of E
   a_data_stable_en: assert property (@(posedge clk) disable iff (!rst_n_i)
      lcd_en_o |=> $stable(lcd_data_o) && $stable(lcd_rs_o));

endmodule

// File: rtl/team_cpu.sv
/*
 * Sequencer: LCD init, then key -> table lookup -> display -> log
 * LCD init runs regardless of en_i; keys offered while en_i is low are dropped
 * Bus requests wait for en_i; log index is 6 bits and wraps after 64 entries
 */
`timescale 1ns/1ps
`include "team_settings.svh"

module team_cpu (
   input  logic                clk,
   input  logic                rst_n_i,
   input  logic                en_i,
   input  logic                key_valid_i,
   input  team_pkg::key_code_t key_code_i,
   output logic                key_ready_o,
   output logic                lcd_valid_o,
   output logic [7:0]          lcd_byte_o,
   output logic                lcd_rs_o,
   input  logic                lcd_ready_i,
   output logic                read_req_o,
   output logic                write_req_o,
   output logic [31:0]         adr_o,
   output logic [31:0]         wdata_o,
   output logic [3:0]          sel_o,
   input  logic                busy_i,
   input  logic [31:0]         rdata_i
);
   import team_pkg::*;

   localparam int COLS   = `TEAM_LCD_COLS;
   localparam int LINE_W = $clog2(COLS + 1);

   cpu_state_e        state;
   logic [1:0]        init_idx;
   logic [LINE_W-1:0] line_cnt;
   logic [5:0]        log_idx;
   logic              req_sent;
   key_code_t         key_q;
   logic [7:0]        char_q;
   lcd_cmd_e          init_cmd;
   logic              lcd_fire;
   logic              key_fire;
   logic              bus_done;

   assign lcd_fire = lcd_valid_o && lcd_ready_i;
   assign key_fire = key_valid_i && key_ready_o;
   // Busy already high the cycle after a request, so this is the true end
   assign bus_done = req_sent && !busy_i;

   // Init command order
   always_comb begin
      case (init_idx)
         2'd0:    init_cmd = LCD_FUNC_SET;
         2'd1:    init_cmd = LCD_DISPLAY_ON;
         default: init_cmd = LCD_CLEAR;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state    <= CPU_INIT;
         init_idx <= 2'd0;
         line_cnt <= '0;
         log_idx  <= '0;
         req_sent <= 1'b0;
      end else begin
         if (read_req_o || write_req_o) req_sent <= 1'b1;
         case (state)
            CPU_INIT: begin
               if (lcd_fire) begin
                  init_idx <= init_idx + 2'd1;
                  if (init_idx == 2'd2) state <= CPU_WAIT_KEY;
               end
            end
            CPU_WAIT_KEY: begin
               // Key taken while disabled is simply dropped
               if (key_fire && en_i) state <= CPU_READ_MAP;
            end
            CPU_READ_MAP: begin
               if (bus_done) begin
                  req_sent <= 1'b0;
                  // Full line gets cleared before the next char
                  state    <= (line_cnt == LINE_W'(COLS)) ? CPU_WRAP : CPU_SHOW;
               end
            end
            CPU_WRAP: begin
               if (lcd_fire) begin
                  line_cnt <= '0;
                  state    <= CPU_SHOW;
               end
            end
            CPU_SHOW: begin
               if (lcd_fire) begin
                  line_cnt <= line_cnt + 1'b1;
                  state    <= CPU_WRITE_LOG;
               end
            end
            CPU_WRITE_LOG: begin
               if (bus_done) begin
                  req_sent <= 1'b0;
                  log_idx  <= log_idx + 6'd1;
                  state    <= CPU_WAIT_KEY;
               end
            end
            default: state <= CPU_INIT;
         endcase
      end
   end

   // Key and looked-up char
   always_ff @(posedge clk) begin
      if (key_fire) key_q <= key_code_i;
      if ((state == CPU_READ_MAP) && bus_done) char_q <= rdata_i[7:0];
   end

   assign key_ready_o = (state == CPU_WAIT_KEY);

   // One-shot requests, held back while disabled
   assign read_req_o  = (state == CPU_READ_MAP) && !req_sent && !busy_i && en_i;
   assign write_req_o = (state == CPU_WRITE_LOG) && !req_sent && !busy_i && en_i;
   assign adr_o       = (state == CPU_WRITE_LOG) ?
                        `TEAM_LOG_BASE + {24'd0, log_idx, 2'b00} :
                        `TEAM_CHARMAP_BASE + {26'd0, key_q, 2'b00};
   assign wdata_o     = {24'd0, char_q};
   assign sel_o       = 4'hF;

   // LCD side, RS high only for characters
   assign lcd_valid_o = (state == CPU_INIT) || (state == CPU_WRAP) || (state == CPU_SHOW);
   assign lcd_rs_o    = (state == CPU_SHOW);
   always_comb begin
      case (state)
         CPU_INIT: lcd_byte_o = init_cmd;
         CPU_WRAP: lcd_byte_o = LCD_CLEAR;
         default:  lcd_byte_o = char_q;
      endcase
   end

endmodule

// File: rtl/team_pkg.sv
/*
 * Shared types for the keypad tile
 * Key code is row * 4 + column, rows and columns counted from 0
 */
package team_pkg;

   // Key number from the scanner
   typedef logic [3:0] key_code_t;

   // HD44780 commands used at init and for line wrap
   typedef enum logic [7:0] {
      LCD_FUNC_SET   = 8'h38,
      LCD_DISPLAY_ON = 8'h0C,
      LCD_CLEAR      = 8'h01
   } lcd_cmd_e;

   // Bus manager
   typedef enum logic {WB_IDLE, WB_BUS} wb_state_e;

   // Keypad scanner
   typedef enum logic [1:0] {SCAN_SEEK, SCAN_OFFER, SCAN_RELEASE} scan_state_e;

   // LCD write phases
   typedef enum logic [1:0] {LCD_IDLE, LCD_SETUP, LCD_PULSE, LCD_HOLD} lcd_state_e;

   // Top sequencer
   typedef enum logic [2:0] {
      CPU_INIT, CPU_WAIT_KEY, CPU_READ_MAP, CPU_SHOW, CPU_WRITE_LOG, CPU_WRAP
   } cpu_state_e;

endpackage

// File: rtl/team_settings.svh
/*
 * Timing divisors, bus addresses and display width for the keypad tile
 * All LCD phase counts must be 1 or more; addresses must be word aligned
 */
`ifndef TEAM_SETTINGS_SVH
`define TEAM_SETTINGS_SVH

// Cycles each keypad column stays driven
`define TEAM_SCAN_DIV 8

// LCD enable timing in clock cycles
`define TEAM_LCD_SETUP 2
`define TEAM_LCD_PULSE 4
`define TEAM_LCD_HOLD  6

// Character table, one word per key, char in low byte
`define TEAM_CHARMAP_BASE 32'h3000_0000
// Log of shown characters, 64 words, wraps
`define TEAM_LOG_BASE     32'h3000_0400

// Characters per display line
`define TEAM_LCD_COLS 16

`endif

// File: rtl/team_top.sv
/*
 * Keypad-to-LCD chip tile behind a Wishbone manager port
 * Pin map: LCD on 11:1 (RW tied low), rows in on 15:12, columns out on 19:16
 * All unused pins are inputs or driven low
 */
`timescale 1ns/1ps

module team_top (
   input  logic        clk,
   input  logic        rst_n_i,
   input  logic        en_i,
   input  logic [33:0] gpio_in_i,
   output logic [33:0] gpio_out_o,
   output logic [33:0] gpio_oeb_o,
   input  logic [31:0] wb_dat_i,
   input  logic        wb_ack_i,
   output logic [31:0] wb_adr_o,
   output logic [31:0] wb_dat_o,
   output logic [3:0]  wb_sel_o,
   output logic        wb_we_o,
   output logic        wb_stb_o,
   output logic        wb_cyc_o
);
   import team_pkg::*;

   // Scanner to cpu
   logic        key_valid;
   logic        key_ready;
   key_code_t   key_code;
   logic [3:0]  cols;
   // Cpu to LCD driver
   logic        lcd_valid;
   logic        lcd_ready;
   logic [7:0]  lcd_byte;
   logic        lcd_rs_req;
   logic        lcd_en;
   logic        lcd_rs;
   logic [7:0]  lcd_data;
   // Cpu to bus manager
   logic        read_req;
   logic        write_req;
   logic        busy;
   logic [31:0] adr;
   logic [31:0] wdata;
   logic [31:0] rdata;
   logic [3:0]  sel;

   wishbone_manager wb_mgr (
      .clk(clk), .rst_n_i(rst_n_i),
      .read_req_i(read_req), .write_req_i(write_req),
      .adr_i(adr), .wdata_i(wdata), .sel_i(sel),
      .busy_o(busy), .rdata_o(rdata),
      .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i),
      .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o), .wb_sel_o(wb_sel_o),
      .wb_we_o(wb_we_o), .wb_stb_o(wb_stb_o), .wb_cyc_o(wb_cyc_o)
   );

   keypad_scanner scanner (
      .clk(clk), .rst_n_i(rst_n_i), .rows_i(gpio_in_i[15:12]), .cols_o(cols),
      .key_valid_o(key_valid), .key_code_o(key_code), .key_ready_i(key_ready)
   );

   lcd_driver lcd (
      .clk(clk), .rst_n_i(rst_n_i),
      .lcd_valid_i(lcd_valid), .lcd_byte_i(lcd_byte), .lcd_rs_i(lcd_rs_req),
      .lcd_ready_o(lcd_ready), .lcd_en_o(lcd_en), .lcd_rs_o(lcd_rs),
      .lcd_data_o(lcd_data)
   );

   team_cpu cpu (
      .clk(clk), .rst_n_i(rst_n_i), .en_i(en_i),
      .key_valid_i(key_valid), .key_code_i(key_code), .key_ready_o(key_ready),
      .lcd_valid_o(lcd_valid), .lcd_byte_o(lcd_byte), .lcd_rs_o(lcd_rs_req),
      .lcd_ready_i(lcd_ready),
      .read_req_o(read_req), .write_req_o(write_req),
      .adr_o(adr), .wdata_o(wdata), .sel_o(sel),
      .busy_i(busy), .rdata_i(rdata)
   );

   // Pin 3 is LCD RW, write only
   assign gpio_out_o = {14'd0, cols, 4'd0, lcd_data, 1'b0, lcd_rs, lcd_en, 1'b0};
   // Low enables the driver; rows and upper pins are inputs
   assign gpio_oeb_o = {14'h3FFF, 4'b0000, 4'b1111, 8'h00, 3'b000, 1'b0};

endmodule

// File: rtl/wishbone_manager.sv
/*
 * Single classic Wishbone transfers only, no block or pipelined cycles
 * ERR and RTY are not handled; a missing ack hangs the manager
 * Requests are one cycle wide and must only come while busy is low
 */
`timescale 1ns/1ps

module wishbone_manager (
   input  logic        clk,
   input  logic        rst_n_i,
   input  logic        read_req_i,
   input  logic        write_req_i,
   input  logic [31:0] adr_i,
   input  logic [31:0] wdata_i,
   input  logic [3:0]  sel_i,
   output logic        busy_o,
   output logic [31:0] rdata_o,
   input  logic [31:0] wb_dat_i,
   input  logic        wb_ack_i,
   output logic [31:0] wb_adr_o,
   output logic [31:0] wb_dat_o,
   output logic [3:0]  wb_sel_o,
   output logic        wb_we_o,
   output logic        wb_stb_o,
   output logic        wb_cyc_o
);
   import team_pkg::*;

   wb_state_e state;
   logic      start;

   assign start = (state == WB_IDLE) && (read_req_i || write_req_i);

   // Control state
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state   <= WB_IDLE;
         wb_we_o <= 1'b0;
      end else begin
         case (state)
            WB_IDLE: begin
               if (start) begin
                  state   <= WB_BUS;
                  // Write wins if both arrive together
                  wb_we_o <= write_req_i;
               end
            end
            WB_BUS: begin
               if (wb_ack_i) begin
                  state   <= WB_IDLE;
                  wb_we_o <= 1'b0;
               end
            end
            default: state <= WB_IDLE;
         endcase
      end
   end

   // Address, data and byte lanes held for the whole cycle
   always_ff @(posedge clk) begin
      if (start) begin
         wb_adr_o <= adr_i;
         wb_dat_o <= wdata_i;
         wb_sel_o <= sel_i;
      end
   end

   // Read data kept until the next request
   always_ff @(posedge clk) begin
      if ((state == WB_BUS) && wb_ack_i && !wb_we_o) begin
         rdata_o <= wb_dat_i;
      end
   end

   // Cycle and strobe together, busy tracks them
   assign wb_cyc_o = (state == WB_BUS);
   assign wb_stb_o = (state == WB_BUS);
   assign busy_o   = (state == WB_BUS);

   // Caller keeps to the request/busy rule
   a_no_req_while_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
      (read_req_i || write_req_i) |-> !busy_o);

   // Bus held steady while the slave stalls
   a_bus_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
      (wb_stb_o && !wb_ack_i) |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_dat_o)
                                  && $stable(wb_sel_o) && $stable(wb_we_o));

endmodule
